//--- tb.f
logic/dcache_pkg.sv
logic/line_store.sv
logic/lookup_stage.sv
logic/access_stage.sv
logic/refill_ctrl.sv
logic/dcache_top.sv
sim/dcache_tb.sv

//--- sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    localparam int cycle_limit = 2000;

    logic CLK;
    logic RST;
    cpu_req_t req;
    logic req_valid;
    logic ready;
    logic resp_valid;
    logic [data_width-1:0] resp_data;
    logic l2_rd_valid;
    line_addr_t l2_rd_addr;
    logic l2_fill_valid = 1'b0;
    line_t l2_fill_data = '0;
    logic l2_wb_valid;
    line_addr_t l2_wb_addr;
    line_t l2_wb_data;
    logic l2_wb_done = 1'b0;

    logic [63:0] l2_mem [logic [28:0]];
    logic [7:0] ref_bytes [logic [31:0]];
    logic exp_chk [32];
    logic [63:0] exp_word [32];
    logic [4:0] req_count;
    logic [4:0] resp_count;
    logic cur_chk;
    logic [63:0] cur_exp;
    logic expect_hit;
    logic expect_wb;
    logic wb_seen = 1'b0;
    logic fill_pending = 1'b0;
    line_addr_t exp_rd_addr;
    line_addr_t exp_wb_addr;
    line_addr_t fill_addr;
    line_addr_t wb_addr_now;
    line_addr_t rd_addr_now;
    line_t exp_wb_line;
    line_t wb_data_now;
    logic rd_now;
    logic fill_now;
    logic wb_now;
    logic wb_done_now;
    logic wb_busy;
    int fill_wait;
    int wb_wait;
    int cycle_count = 0;
    integer seed;
    string test_name;

    dcache_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // untouched memory holds a pattern built from the word address
    function automatic logic [63:0] default_word(input logic [28:0] wa);
        return {3'b000, wa, 32'h9e37_79b9 ^ {3'b000, wa}};
    endfunction

    function automatic logic [63:0] ref_word(input logic [31:0] addr);
        logic [63:0] word;
        logic [31:0] key;
        word = default_word(addr[31:3]);
        for (int b = 0; b < strb_width; b++) begin
            key = {addr[31:3], 3'b000} + 32'(b);
            if (ref_bytes.exists(key)) word[b*8 +: 8] = ref_bytes[key];
        end
        return word;
    endfunction

    function automatic line_t ref_line(input line_addr_t la);
        line_t line;
        for (int w = 0; w < words_per_line; w++) begin
            line[w*data_width +: data_width] = ref_word({la, w[1:0], 3'b000});
        end
        return line;
    endfunction

    function automatic line_t read_l2_line(input line_addr_t la);
        line_t line;
        logic [28:0] wa;
        for (int w = 0; w < words_per_line; w++) begin
            wa = {la, w[1:0]};
            line[w*data_width +: data_width] = l2_mem.exists(wa) ? l2_mem[wa] : default_word(wa);
        end
        return line;
    endfunction

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] act);
        $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s in test %s", what, test_name);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // one request, held until the cache takes it
    task automatic send(input logic [31:0] addr, input logic we, input logic [7:0] strb,
                        input logic [63:0] data);
        req.addr.flat = addr;
        req.we = we;
        req.wstrb = strb;
        req.wdata = data;
        req_valid = 1'b1;
        if (we) begin
            for (int b = 0; b < strb_width; b++) begin
                if (strb[b]) ref_bytes[{addr[31:3], 3'b000} + 32'(b)] = data[b*8 +: 8];
            end
        end
        exp_chk[req_count] = !we;
        exp_word[req_count] = ref_word(addr);
        @(posedge CLK);
        while (!ready) @(posedge CLK);
        req_count = req_count + 1'b1;
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge CLK);
        while (resp_count != req_count) @(posedge CLK);
        #1;
    endtask

    always @(posedge CLK) begin
        if (RST) resp_count <= '0;
        else if (resp_valid) resp_count <= resp_count + 1'b1;
    end

    assign cur_chk = exp_chk[resp_count];
    assign cur_exp = exp_word[resp_count];

    // L2 model, sampled at the edge and driven just after it
    always @(posedge CLK) begin
        rd_now = l2_rd_valid;
        rd_addr_now = l2_rd_addr;
        fill_now = l2_fill_valid;
        wb_now = l2_wb_valid;
        wb_done_now = l2_wb_done;
        wb_addr_now = l2_wb_addr;
        wb_data_now = l2_wb_data;
        #1;
        l2_fill_valid = 1'b0;
        l2_wb_done = 1'b0;
        if (RST) begin
            fill_wait = 0;
            wb_wait = 0;
            wb_busy = 1'b0;
        end else begin
            if (fill_now) fill_pending = 1'b0;
            if (rd_now) begin
                fill_addr = rd_addr_now;
                fill_wait = 3;
                fill_pending = 1'b1;
            end else if (fill_wait == 1) begin
                l2_fill_data = read_l2_line(fill_addr);
                l2_fill_valid = 1'b1;
                fill_wait = 0;
            end else if (fill_wait > 1) begin
                fill_wait = fill_wait - 1;
            end
            if (wb_done_now) begin
                for (int w = 0; w < words_per_line; w++) begin
                    l2_mem[{wb_addr_now, w[1:0]}] = wb_data_now[w*data_width +: data_width];
                end
                wb_busy = 1'b0;
            end else if (wb_now && !wb_busy) begin
                wb_busy = 1'b1;
                wb_seen = 1'b1;
                wb_wait = 2;
            end else if (wb_wait == 1) begin
                l2_wb_done = 1'b1;
                wb_wait = 0;
            end else if (wb_wait > 1) begin
                wb_wait = wb_wait - 1;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    a_reset_state: assert property (@(posedge CLK)
        $fell(RST) |-> {ready, resp_valid, l2_rd_valid, l2_wb_valid} == 4'b1000)
        else report_mismatch(test_name, 4'b1000,
                             $sampled({ready, resp_valid, l2_rd_valid, l2_wb_valid}));
    a_load_data: assert property (@(posedge CLK) disable iff (RST)
        resp_valid && cur_chk |-> resp_data == cur_exp)
        else report_mismatch(test_name, $sampled(cur_exp), $sampled(resp_data));
    a_hit_latency: assert property (@(posedge CLK) disable iff (RST)
        req_valid && ready && expect_hit |-> ##2 resp_valid)
        else report_failure("hit response missing two cycles after accept");
    a_no_l2_on_hit: assert property (@(posedge CLK) disable iff (RST)
        expect_hit |-> !l2_rd_valid && !l2_wb_valid)
        else report_failure("L2 traffic during a cache hit");
    a_rd_addr: assert property (@(posedge CLK) disable iff (RST)
        l2_rd_valid |-> l2_rd_addr == exp_rd_addr)
        else report_mismatch(test_name, $sampled(exp_rd_addr), $sampled(l2_rd_addr));
    a_ready_in_fill: assert property (@(posedge CLK) disable iff (RST)
        fill_pending |-> !ready)
        else report_failure("ready high while a line fill is pending");
    a_wb_expected: assert property (@(posedge CLK) disable iff (RST)
        l2_wb_valid |-> expect_wb)
        else report_failure("unexpected writeback to L2");
    a_wb_addr: assert property (@(posedge CLK) disable iff (RST)
        l2_wb_valid |-> l2_wb_addr == exp_wb_addr)
        else report_mismatch(test_name, $sampled(exp_wb_addr), $sampled(l2_wb_addr));
    a_wb_data: assert property (@(posedge CLK) disable iff (RST)
        l2_wb_valid |-> l2_wb_data == exp_wb_line)
        else report_mismatch(test_name, $sampled(exp_wb_line), $sampled(l2_wb_data));
    a_wb_first: assert property (@(posedge CLK) disable iff (RST)
        l2_rd_valid && expect_wb |-> wb_seen)
        else report_failure("line fetch issued before the dirty writeback");

    initial begin
        seed = 32'h6b4e;
        RST = 1'b1;
        req = '0;
        req_valid = 1'b0;
        req_count = '0;
        expect_hit = 1'b0;
        expect_wb = 1'b0;
        exp_rd_addr = '0;
        exp_wb_addr = '0;
        exp_wb_line = '0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) begin
            exp_chk[i] = 1'b0;
            exp_word[i] = '0;
        end
        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;

        // index 2 for the first line, index 5 for the evicted pair
        test_name = "cold_load";
        exp_rd_addr = 27'h0000_082;
        send(32'h0000_1048, 1'b0, '0, '0);
        wait_idle();

        test_name = "repeat_hit";
        expect_hit = 1'b1;
        send(32'h0000_1050, 1'b0, '0, '0);
        send(32'h0000_1048, 1'b0, '0, '0);
        wait_idle();

        test_name = "store_forward";
        send(32'h0000_1048, 1'b1, $random(seed), {$random(seed), $random(seed)});
        send(32'h0000_1048, 1'b0, '0, '0);
        wait_idle();
        expect_hit = 1'b0;

        test_name = "store_miss";
        exp_rd_addr = 27'h0000_105;
        send(32'h0000_20a0, 1'b1, $random(seed), {$random(seed), $random(seed)});
        wait_idle();
        expect_hit = 1'b1;
        send(32'h0000_20b0, 1'b0, '0, '0);
        send(32'h0000_20a0, 1'b0, '0, '0);
        wait_idle();
        expect_hit = 1'b0;

        test_name = "dirty_evict";
        expect_wb = 1'b1;
        exp_wb_addr = 27'h0000_105;
        exp_wb_line = ref_line(27'h0000_105);
        exp_rd_addr = 27'h0000_115;
        send(32'h0000_22a0, 1'b0, '0, '0);
        wait_idle();
        expect_wb = 1'b0;

        test_name = "reload_evicted";
        exp_rd_addr = 27'h0000_105;
        send(32'h0000_20a0, 1'b0, '0, '0);
        wait_idle();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire dcache_pkg::cpu_req_t req,
    input  wire                      req_valid,
    output logic                     ready,
    output logic                     resp_valid,
    output logic [dcache_pkg::data_width-1:0] resp_data,
    output logic                     l2_rd_valid,
    output dcache_pkg::line_addr_t   l2_rd_addr,
    input  wire                      l2_fill_valid,
    input  wire dcache_pkg::line_t   l2_fill_data,
    output logic                     l2_wb_valid,
    output dcache_pkg::line_addr_t   l2_wb_addr,
    output dcache_pkg::line_t        l2_wb_data,
    input  wire                      l2_wb_done
);
    import dcache_pkg::*;

    logic [index_width-1:0] rd_index;
    cpu_req_t               s1_req;
    logic                   s1_valid;
    line_t                  rd_line;
    tag_entry_t             rd_tag;
    array_wr_t              hit_wr;
    array_wr_t              fill_wr;
    logic                   miss;
    tag_entry_t             victim_tag;
    line_t                  victim_line;
    line_t                  merged_line;
    line_t                  fill_line;
    logic                   refill_done;

    lookup_stage u_lookup (
        .CLK         (CLK),
        .RST         (RST),
        .req         (req),
        .req_valid   (req_valid),
        .ready       (ready),
        .refill_done (refill_done),
        .rd_index    (rd_index),
        .s1_req      (s1_req),
        .s1_valid    (s1_valid)
    );

    line_store u_store (
        .CLK      (CLK),
        .RST      (RST),
        .rd_index (rd_index),
        .rd_line  (rd_line),
        .rd_tag   (rd_tag),
        .hit_wr   (hit_wr),
        .fill_wr  (fill_wr)
    );

    access_stage u_access (
        .CLK         (CLK),
        .RST         (RST),
        .s1_req      (s1_req),
        .s1_valid    (s1_valid),
        .rd_line     (rd_line),
        .rd_tag      (rd_tag),
        .fill_line   (fill_line),
        .refill_done (refill_done),
        .ready       (ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .hit_wr      (hit_wr),
        .miss        (miss),
        .victim_tag  (victim_tag),
        .victim_line (victim_line),
        .merged_line (merged_line)
    );

    refill_ctrl u_refill (
        .CLK           (CLK),
        .RST           (RST),
        .miss          (miss),
        .s1_req        (s1_req),
        .victim_tag    (victim_tag),
        .victim_line   (victim_line),
        .merged_line   (merged_line),
        .l2_rd_valid   (l2_rd_valid),
        .l2_rd_addr    (l2_rd_addr),
        .l2_fill_valid (l2_fill_valid),
        .l2_fill_data  (l2_fill_data),
        .l2_wb_valid   (l2_wb_valid),
        .l2_wb_addr    (l2_wb_addr),
        .l2_wb_data    (l2_wb_data),
        .l2_wb_done    (l2_wb_done),
        .fill_line     (fill_line),
        .fill_wr       (fill_wr),
        .refill_done   (refill_done)
    );

endmodule

`default_nettype wire

//--- logic/refill_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          miss,
    input  wire dcache_pkg::cpu_req_t    s1_req,
    input  wire dcache_pkg::tag_entry_t  victim_tag,
    input  wire dcache_pkg::line_t       victim_line,
    input  wire dcache_pkg::line_t       merged_line,
    output logic                         l2_rd_valid,
    output dcache_pkg::line_addr_t       l2_rd_addr,
    input  wire                          l2_fill_valid,
    input  wire dcache_pkg::line_t       l2_fill_data,
    output logic                         l2_wb_valid,
    output dcache_pkg::line_addr_t       l2_wb_addr,
    output dcache_pkg::line_t            l2_wb_data,
    input  wire                          l2_wb_done,
    output dcache_pkg::line_t            fill_line,
    output dcache_pkg::array_wr_t        fill_wr,
    output logic                         refill_done
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_request,
        st_wait_fill
    } state_t;

    state_t state;

    // one-cycle read pulse, the missed request is held upstream meanwhile
    assign l2_rd_valid = (state == st_request);
    assign l2_rd_addr  = s1_req.addr.flat[addr_width-1:offset_width];

    assign refill_done = (state == st_wait_fill) && l2_fill_valid;
    assign fill_line   = l2_fill_data;

    always_ff @(posedge CLK) begin
        if (state == st_idle) begin
            l2_wb_addr <= {victim_tag.tag, s1_req.addr.fields.index};
            l2_wb_data <= victim_line;
        end
        fill_wr.index       <= s1_req.addr.fields.index;
        fill_wr.line        <= merged_line;
        fill_wr.entry.valid <= 1'b1;
        fill_wr.entry.dirty <= s1_req.we;
        fill_wr.entry.tag   <= s1_req.addr.fields.tag;

        if (RST) begin
            state       <= st_idle;
            l2_wb_valid <= 1'b0;
            fill_wr.en  <= 1'b0;
        end else begin
            fill_wr.en <= refill_done;
            case (state)
                st_idle: begin
                    if (miss) begin
                        if (victim_tag.valid && victim_tag.dirty) begin
                            state       <= st_write_back;
                            l2_wb_valid <= 1'b1;
                        end else begin
                            state <= st_request;
                        end
                    end
                end
                st_write_back: begin
                    // hold until L2 takes the dirty line
                    if (l2_wb_done) begin
                        l2_wb_valid <= 1'b0;
                        state       <= st_request;
                    end
                end
                st_request: begin
                    state <= st_wait_fill;
                end
                st_wait_fill: begin
                    if (l2_fill_valid) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // writeback must finish before the line fetch goes out
    a_wb_before_rd: assert property (@(posedge CLK) disable iff (RST)
        !(l2_rd_valid && l2_wb_valid))
        else $error("refill_ctrl: line fetch during writeback");

endmodule

`default_nettype wire

//--- logic/access_stage.sv
`timescale 1ns/1ps
`default_nettype none

module access_stage (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire dcache_pkg::cpu_req_t    s1_req,
    input  wire                          s1_valid,
    input  wire dcache_pkg::line_t       rd_line,
    input  wire dcache_pkg::tag_entry_t  rd_tag,
    input  wire dcache_pkg::line_t       fill_line,
    input  wire                          refill_done,
    output logic                         ready,
    output logic                         resp_valid,
    output logic [dcache_pkg::data_width-1:0] resp_data,
    output dcache_pkg::array_wr_t        hit_wr,
    output logic                         miss,
    output dcache_pkg::tag_entry_t       victim_tag,
    output dcache_pkg::line_t            victim_line,
    output dcache_pkg::line_t            merged_line
);
    import dcache_pkg::*;

    logic  hit;
    logic  lookup_miss;
    line_t hit_line;

    function automatic logic [data_width-1:0] pick_word(
        input line_t                     line,
        input logic [word_sel_width-1:0] sel
    );
        return line[sel*data_width +: data_width];
    endfunction

    // strobed bytes of the store replace the addressed word
    function automatic line_t apply_store(input line_t base, input cpu_req_t r);
        line_t result;
        result = base;
        for (int b = 0; b < strb_width; b++) begin
            if (r.wstrb[b]) begin
                result[r.addr.fields.word*data_width + b*8 +: 8] = r.wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign hit         = rd_tag.valid && (rd_tag.tag == s1_req.addr.fields.tag);
    assign lookup_miss = s1_valid && !hit;
    assign ready       = !lookup_miss;

    // array keeps re-reading the held index, so the victim stays put
    assign victim_tag  = rd_tag;
    assign victim_line = rd_line;

    assign hit_line    = s1_req.we ? apply_store(rd_line, s1_req) : rd_line;
    assign merged_line = s1_req.we ? apply_store(fill_line, s1_req) : fill_line;

    always_ff @(posedge CLK) begin
        if (refill_done) begin
            resp_data <= pick_word(merged_line, s1_req.addr.fields.word);
        end else begin
            resp_data <= pick_word(hit_line, s1_req.addr.fields.word);
        end
        hit_wr.index       <= s1_req.addr.fields.index;
        hit_wr.line        <= hit_line;
        hit_wr.entry.valid <= 1'b1;
        hit_wr.entry.dirty <= 1'b1;
        hit_wr.entry.tag   <= s1_req.addr.fields.tag;

        if (RST) begin
            resp_valid <= 1'b0;
            miss       <= 1'b0;
            hit_wr.en  <= 1'b0;
        end else begin
            resp_valid <= (s1_valid && hit) || refill_done;
            miss       <= lookup_miss && !refill_done;
            hit_wr.en  <= s1_valid && hit && s1_req.we;
        end
    end

    // a miss drops only with the fill response, which lands after it
    a_resp_not_in_miss: assert property (@(posedge CLK) disable iff (RST)
        !(resp_valid && miss))
        else $error("access_stage: response while a miss is open");

endmodule

`default_nettype wire

//--- logic/lookup_stage.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_stage (
    input  wire                           CLK,
    input  wire                           RST,
    input  wire dcache_pkg::cpu_req_t     req,
    input  wire                           req_valid,
    input  wire                           ready,
    input  wire                           refill_done,
    output logic [dcache_pkg::index_width-1:0] rd_index,
    output dcache_pkg::cpu_req_t          s1_req,
    output logic                          s1_valid
);
    import dcache_pkg::*;

    logic accept;

    assign accept = req_valid && ready;

    // new request reads at its accept edge, a stalled one reads its line again
    assign rd_index = accept ? req.addr.fields.index : s1_req.addr.fields.index;

    always_ff @(posedge CLK) begin
        if (RST) begin
            s1_valid <= 1'b0;
        end else if (ready) begin
            s1_valid <= req_valid;
        end else if (refill_done) begin
            // missed request is answered from the fill line
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            s1_req <= req;
        end
    end

endmodule

`default_nettype wire

//--- logic/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire [dcache_pkg::index_width-1:0] rd_index,
    output dcache_pkg::line_t            rd_line,
    output dcache_pkg::tag_entry_t       rd_tag,
    input  wire dcache_pkg::array_wr_t   hit_wr,
    input  wire dcache_pkg::array_wr_t   fill_wr
);
    import dcache_pkg::*;

    line_t                  data_mem [line_count];
    logic [tag_width-1:0]   tag_mem [line_count];
    logic [line_count-1:0]  valid_bits;
    logic [line_count-1:0]  dirty_bits;

    array_wr_t              wr;
    logic [index_width-1:0] rd_index_q;
    line_t                  line_q;
    tag_entry_t             tag_q;

    // refill install wins over a store hit
    assign wr = fill_wr.en ? fill_wr : hit_wr;

    always_ff @(posedge CLK) begin
        if (wr.en) begin
            data_mem[wr.index] <= wr.line;
            tag_mem[wr.index]  <= wr.entry.tag;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (wr.en) begin
            valid_bits[wr.index] <= wr.entry.valid;
            dirty_bits[wr.index] <= wr.entry.dirty;
        end
    end

    // registered read, write on the same edge bypasses the array
    always_ff @(posedge CLK) begin
        rd_index_q <= rd_index;
        if (wr.en && wr.index == rd_index) begin
            line_q <= wr.line;
            tag_q  <= wr.entry;
        end else begin
            line_q      <= data_mem[rd_index];
            tag_q.valid <= valid_bits[rd_index];
            tag_q.dirty <= dirty_bits[rd_index];
            tag_q.tag   <= tag_mem[rd_index];
        end
    end

    // write landing at the end of the output cycle
    always_comb begin
        rd_line = line_q;
        rd_tag  = tag_q;
        if (wr.en && wr.index == rd_index_q) begin
            rd_line = wr.line;
            rd_tag  = wr.entry;
        end
    end

    // store hits stop while a miss is open, so the two writers never meet
    a_one_writer: assert property (@(posedge CLK) disable iff (RST)
        !(hit_wr.en && fill_wr.en))
        else $error("line_store: hit and fill write in the same cycle");

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int addr_width     = 32;
    localparam int data_width     = 64;
    localparam int words_per_line = 4;
    localparam int line_count     = 16;

    localparam int strb_width     = data_width / 8;
    localparam int byte_sel_width = $clog2(strb_width);
    localparam int word_sel_width = $clog2(words_per_line);
    localparam int offset_width   = word_sel_width + byte_sel_width;
    localparam int index_width    = $clog2(line_count);
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int line_width     = words_per_line * data_width;

    // lookup view of a request address
    typedef struct packed {
        logic [tag_width-1:0]      tag;
        logic [index_width-1:0]    index;
        logic [word_sel_width-1:0] word;
        logic [byte_sel_width-1:0] byte_off;
    } addr_fields_t;

    // flat form feeds the L2 line address, fields feed the lookup
    typedef union packed {
        logic [addr_width-1:0] flat;
        addr_fields_t          fields;
    } cache_addr_t;

    typedef logic [addr_width-offset_width-1:0] line_addr_t;

    typedef struct packed {
        cache_addr_t           addr;
        logic                  we;
        logic [strb_width-1:0] wstrb;
        logic [data_width-1:0] wdata;
    } cpu_req_t;

    typedef logic [line_width-1:0] line_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_width-1:0] tag;
    } tag_entry_t;

    // one write into the line store
    typedef struct packed {
        logic                   en;
        logic [index_width-1:0] index;
        line_t                  line;
        tag_entry_t             entry;
    } array_wr_t;

endpackage

`default_nettype wire
